// ==== l2dir.f ====
hw/l2dir_pkg.sv
hw/l2dir_stage_ifs.sv
hw/l1_dir_tags.sv
hw/l2_tag_stage.sv
hw/l2_dir_stage.sv
hw/l2_resp_stage.sv
hw/l2_dir_top.sv
tests/tb_clock_gen.sv
tests/tb_l2_dir_top.sv

// ==== tests/tb_l2_dir_top.sv ====
// Simulation top that drives the L2 directory over Wishbone and checks it against a model
`default_nettype none

module tb_l2_dir_top;
	import l2dir_pkg::*;

	localparam int NUM_REQUESTS = 320;
	localparam int CYCLE_LIMIT = NUM_REQUESTS * 6 + 100;
	localparam int DRIVE_DELAY = 1;
	localparam int RANDOM_OPS = 300;

	logic clk;
	logic reset_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	line_addr_t wb_adr;
	l2_op_e wb_tgc;
	way_t wb_tga;
	logic wb_ack;
	wb_data_t wb_dat;

	wb_data_t expected_word;
	wb_data_t care_mask;
	logic pending;
	int errors;
	int checks;
	int requests;
	int cycles;
	int test_errors;
	int test_requests;
	logic [31:0] rnd_state;

	// Reference model state
	l2_tag_t m_tag [L2_NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS-1:0] m_valid [L2_NUM_SETS];
	logic [NUM_WAYS-1:0] m_dirty [L2_NUM_SETS];
	way_t m_rr [L2_NUM_SETS];
	l1_tag_t m_l1_tag [L1_NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS-1:0] m_l1_valid [L1_NUM_SETS];

	tb_clock_gen clock_gen (
		.clk_o    (clk),
		.reset_n_o(reset_n)
	);

	l2_dir_top UUT (
		.clk     (clk),
		.reset_n (reset_n),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_we_i (wb_we),
		.wb_adr_i(wb_adr),
		.wb_tgc_i(wb_tgc),
		.wb_tga_i(wb_tga),
		.wb_ack_o(wb_ack),
		.wb_dat_o(wb_dat)
	);

	response_matches: assert property (@(posedge clk) disable iff (!reset_n)
		wb_ack |-> (((wb_dat ^ expected_word) & care_mask) == '0))
	else
	begin
		$display("ERROR at time %0t: response %h, expected %h under mask %h",
			$time, $sampled(wb_dat), expected_word, care_mask);
		errors++;
	end

	ack_latency: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(wb_cyc && wb_stb) |-> !wb_ack [*3] ##1 wb_ack)
	else
	begin
		$display("Acknowledge did not come exactly 3 cycles after the request (time %0t)", $time);
		errors++;
	end

	ack_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		wb_ack |=> !wb_ack)
	else
	begin
		$display("Acknowledge stayed high for more than one cycle (time %0t)", $time);
		errors++;
	end

	// Also covers the quiet period right after reset
	ack_only_when_pending: assert property (@(posedge clk) disable iff (!reset_n)
		wb_ack |-> pending)
	else
	begin
		$display("Acknowledge came with no request outstanding (time %0t)", $time);
		errors++;
	end

	function automatic logic [31:0] next_random(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic line_addr_t make_addr(input l2_tag_t tag, input l2_set_t l2_set);
		return {tag, l2_set};
	endfunction

	// Predicts the response word of one request and applies it to the model
	function automatic void predict_response(input l2_op_e op, input line_addr_t addr,
		input way_t l1_way);
		l2_set_t l2_set;
		l2_tag_t tag;
		l1_set_t l1_set;
		l1_tag_t l1_tag;
		logic hit;
		way_t way;
		logic l1_hit;
		way_t l1_hit_way;
		l2_set = addr[L2_SET_WIDTH-1:0];
		tag = addr[LINE_ADDR_WIDTH-1 -: L2_TAG_WIDTH];
		l1_set = addr[L1_SET_WIDTH-1:0];
		l1_tag = addr[LINE_ADDR_WIDTH-1 -: L1_TAG_WIDTH];
		hit = 1'b0;
		way = '0;
		l1_hit = 1'b0;
		l1_hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (m_valid[l2_set][w] && (m_tag[l2_set][w] == tag))
			begin
				hit = 1'b1;
				way = way_t'(w);
			end
			if (m_l1_valid[l1_set][w] && (m_l1_tag[l1_set][w] == l1_tag))
			begin
				l1_hit = 1'b1;
				l1_hit_way = way_t'(w);
			end
		end
		// Fill of a present line refills its own way
		if ((op == OP_FILL) && !hit)
		begin
			if (&m_valid[l2_set])
			begin
				way = m_rr[l2_set];
				m_rr[l2_set] = m_rr[l2_set] + 1'b1;
			end
			else
			begin
				for (int w = NUM_WAYS - 1; w >= 0; w--)
					if (!m_valid[l2_set][w])
						way = way_t'(w);
			end
		end
		expected_word = '0;
		care_mask = '1;
		expected_word[RSP_HIT_BIT] = hit;
		expected_word[RSP_WAY_LSB +: $bits(way_t)] = way;
		expected_word[RSP_DIRTY_BIT] = (hit || (op == OP_FILL)) && m_dirty[l2_set][way];
		expected_word[RSP_L1_HIT_BIT] = l1_hit;
		expected_word[RSP_L1_WAY_LSB +: $bits(way_t)] = l1_hit_way;
		if (op == OP_FILL)
		begin
			expected_word[RSP_VICTIM_VALID_BIT] = m_valid[l2_set][way];
			if (m_valid[l2_set][way])
				expected_word[RSP_OLD_TAG_LSB +: L2_TAG_WIDTH] = m_tag[l2_set][way];
			else
				care_mask[RSP_OLD_TAG_LSB +: L2_TAG_WIDTH] = '0; // invalid way holds no defined tag
			m_tag[l2_set][way] = tag;
			m_valid[l2_set][way] = 1'b1;
			m_dirty[l2_set][way] = 1'b0;
		end
		else if (hit && (op == OP_STORE))
			m_dirty[l2_set][way] = 1'b1;
		else if (hit && (op == OP_FLUSH))
			m_dirty[l2_set][way] = 1'b0;
		if (((op == OP_LOAD) && hit) || (op == OP_FILL))
		begin
			// A line sits in one L1 way at most
			for (int w = 0; w < NUM_WAYS; w++)
				if (m_l1_tag[l1_set][w] == l1_tag)
					m_l1_valid[l1_set][w] = 1'b0;
			m_l1_tag[l1_set][l1_way] = l1_tag;
			m_l1_valid[l1_set][l1_way] = 1'b1;
		end
	endfunction

	// One Wishbone classic cycle held open until ack is seen
	task automatic issue_request(input l2_op_e op, input line_addr_t addr, input way_t l1_way);
		predict_response(op, addr, l1_way);
		@(posedge clk);
		#DRIVE_DELAY;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = (op == OP_STORE) || (op == OP_FILL);
		wb_adr = addr;
		wb_tgc = op;
		wb_tga = l1_way;
		pending = 1'b1;
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		@(posedge clk);
		#DRIVE_DELAY;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		pending = 1'b0;
		requests++;
		checks++;
	endtask

	task automatic start_test();
		test_errors = errors;
		test_requests = requests;
	endtask

	task automatic finish_test(input string name);
		$display("Test %s done: %0d requests, %0d errors", name,
			requests - test_requests, errors - test_errors);
	endtask

	task automatic print_counts();
		$display("Requests %0d, response checks %0d, errors %0d", requests, checks, errors);
	endtask

	initial
	begin
		l2_op_e op;
		l2_tag_t tag;
		l2_set_t l2_set;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_tgc = OP_LOAD;
		wb_tga = '0;
		pending = 1'b0;
		expected_word = '0;
		care_mask = '1;
		errors = 0;
		checks = 0;
		requests = 0;
		rnd_state = 32'd60782;
		for (int s = 0; s < L2_NUM_SETS; s++)
		begin
			m_valid[s] = '0;
			m_dirty[s] = '0;
			m_rr[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++)
				m_tag[s][w] = '0;
		end
		for (int s = 0; s < L1_NUM_SETS; s++)
		begin
			m_l1_valid[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++)
				m_l1_tag[s][w] = '0;
		end
		@(posedge reset_n);
		start_test();
		repeat (4) @(posedge clk);
		issue_request(OP_LOAD, make_addr(11'h012, 5'd1), 2'd0);
		finish_test("reset");

		start_test();
		for (int w = 0; w < NUM_WAYS; w++)
			issue_request(OP_FILL, make_addr(11'h100 + l2_tag_t'(w), 5'd2), way_t'(w));
		for (int w = 0; w < NUM_WAYS; w++)
			issue_request(OP_LOAD, make_addr(11'h100 + l2_tag_t'(w), 5'd2), way_t'(w));
		finish_test("fill_and_hit");

		start_test();
		issue_request(OP_STORE, make_addr(11'h101, 5'd2), 2'd0);
		issue_request(OP_STORE, make_addr(11'h101, 5'd2), 2'd0);
		issue_request(OP_FLUSH, make_addr(11'h101, 5'd2), 2'd0);
		issue_request(OP_LOAD, make_addr(11'h101, 5'd2), 2'd1);
		finish_test("dirty_tracking");

		start_test();
		// Dirty the round-robin victim first
		issue_request(OP_STORE, make_addr(11'h100, 5'd2), 2'd0);
		issue_request(OP_FILL, make_addr(11'h104, 5'd2), 2'd2);
		issue_request(OP_LOAD, make_addr(11'h100, 5'd2), 2'd0);
		finish_test("eviction");

		start_test();
		issue_request(OP_FILL, make_addr(11'h055, 5'd9), 2'd2);
		issue_request(OP_LOAD, make_addr(11'h055, 5'd9), 2'd1);
		issue_request(OP_STORE, make_addr(11'h055, 5'd9), 2'd3);
		// Same L1 set as the line above, other tag
		issue_request(OP_LOAD, make_addr(11'h077, 5'd9), 2'd0);
		finish_test("l1_directory");

		start_test();
		// Two L2 sets sharing one L1 set with six tags each
		for (int i = 0; i < RANDOM_OPS; i++)
		begin
			rnd_state = next_random(rnd_state);
			op = l2_op_e'(rnd_state[1:0]);
			tag = 11'h200 + l2_tag_t'(rnd_state[7:5] % 6);
			l2_set = rnd_state[4] ? 5'd3 : 5'd19;
			issue_request(op, make_addr(tag, l2_set), way_t'(rnd_state[3:2]));
		end
		finish_test("random_mix");

		print_counts();
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Run timed out after %0d cycles", cycles);
		print_counts();
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// Testbench clock and reset source, instanced by the testbench top with a 10-unit clock period
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic reset_n_o
);

	initial
	begin
		clk_o = 1'b0;
		reset_n_o = 1'b0;
		// Reset held low for three rising edges
		repeat (3) @(posedge clk_o);
		#1;
		reset_n_o = 1'b1;
	end

	always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== hw/l2_dir_top.sv ====
// Top level of the L2 directory pipeline with a Wishbone classic slave port
`default_nettype none

module l2_dir_top (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	// Operation comes from wb_tgc_i, so write enable is ignored
	input  logic                  wb_we_i,
	input  l2dir_pkg::line_addr_t wb_adr_i,
	input  l2dir_pkg::l2_op_e     wb_tgc_i,
	input  l2dir_pkg::way_t       wb_tga_i,
	output logic                  wb_ack_o,
	output l2dir_pkg::wb_data_t   wb_dat_o
);

	logic release_req;

	l2_req_if req_if ();
	l2_result_if res_if ();

	l2_tag_stage tag_stage (
		.clk      (clk),
		.reset_n  (reset_n),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_adr_i (wb_adr_i),
		.wb_tgc_i (wb_tgc_i),
		.wb_tga_i (wb_tga_i),
		.release_i(release_req),
		.req_o    (req_if.ready)
	);

	l2_dir_stage dir_stage (
		.clk    (clk),
		.reset_n(reset_n),
		.req_i  (req_if.dir),
		.res_o  (res_if.dir)
	);

	l2_resp_stage resp_stage (
		.clk      (clk),
		.reset_n  (reset_n),
		.res_i    (res_if.resp),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_ack_o (wb_ack_o),
		.wb_dat_o (wb_dat_o),
		.release_o(release_req)
	);

endmodule

`default_nettype wire

// ==== hw/l2_resp_stage.sv ====
// Response stage: packs directory results into the Wishbone read data and acknowledges
`default_nettype none

module l2_resp_stage (
	input  logic                clk,
	input  logic                reset_n,
	l2_result_if.resp           res_i,
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	output logic                wb_ack_o,
	output l2dir_pkg::wb_data_t wb_dat_o,
	output logic                release_o
);
	import l2dir_pkg::*;

	wb_data_t rsp_word;
	logic ack_q;

	always_comb
	begin
		rsp_word = '0;
		rsp_word[RSP_HIT_BIT] = res_i.hit;
		rsp_word[RSP_WAY_LSB +: $bits(way_t)] = res_i.way;
		rsp_word[RSP_DIRTY_BIT] = res_i.dirty;
		rsp_word[RSP_L1_HIT_BIT] = res_i.l1_hit;
		rsp_word[RSP_L1_WAY_LSB +: $bits(way_t)] = res_i.l1_way;
		// Zero unless the request was a fill
		rsp_word[RSP_OLD_TAG_LSB +: L2_TAG_WIDTH] = res_i.old_tag;
		rsp_word[RSP_VICTIM_VALID_BIT] = res_i.victim_valid;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			ack_q <= 1'b0;
		else
			ack_q <= res_i.valid;
	end

	always_ff @(posedge clk)
	begin
		if (res_i.valid)
			wb_dat_o <= rsp_word;
	end

	assign wb_ack_o = ack_q;
	// Frees the tag stage for the next request
	assign release_o = ack_q;

	// The master holds the cycle open until it sees ack
	ack_in_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		wb_ack_o |-> (wb_cyc_i && wb_stb_i));

endmodule

`default_nettype wire

// ==== hw/l2_dir_stage.sv ====
// Directory stage: finds the L2 hit way, tracks dirty bits and the L1 directory, registers results
`default_nettype none

module l2_dir_stage (
	input  logic     clk,
	input  logic     reset_n,
	l2_req_if.dir    req_i,
	l2_result_if.dir res_o
);
	import l2dir_pkg::*;

	logic [NUM_WAYS-1:0] dirty_q [L2_NUM_SETS];

	l2_tag_t req_tag;
	l2_set_t req_set;
	logic is_load;
	logic is_store;
	logic is_flush;
	logic is_fill;
	logic [NUM_WAYS-1:0] hit_vec;
	logic hit;
	way_t hit_way;
	way_t sel_way;
	logic old_dirty;
	logic l1_hit;
	way_t l1_way;
	logic l1_update;

	assign req_tag = req_i.addr[LINE_ADDR_WIDTH-1 -: L2_TAG_WIDTH];
	assign req_set = req_i.addr[L2_SET_WIDTH-1:0];
	assign is_load = req_i.op == OP_LOAD;
	assign is_store = req_i.op == OP_STORE;
	assign is_flush = req_i.op == OP_FLUSH;
	assign is_fill = req_i.op == OP_FILL;

	// Compare against the set snapshot from the tag stage
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			hit_vec[w] = req_i.valids[w] && (req_i.tags[w] == req_tag);
			if (hit_vec[w])
				hit_way = way_t'(w);
		end
	end

	assign hit = |hit_vec;

	// A fill reports its victim way, everything else the hit way
	assign sel_way = is_fill ? req_i.fill_way : hit_way;
	assign old_dirty = (hit || is_fill) && dirty_q[req_set][sel_way];

	// Lines handed to the L1 data cache
	assign l1_update = req_i.valid && ((is_load && hit) || is_fill);

	l1_dir_tags l1_dir (
		.clk          (clk),
		.reset_n      (reset_n),
		.lookup_addr_i(req_i.addr),
		.hit_o        (l1_hit),
		.hit_way_o    (l1_way),
		.update_i     (l1_update),
		.update_way_i (req_i.l1_way),
		.update_addr_i(req_i.addr)
	);

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			for (int s = 0; s < L2_NUM_SETS; s++)
				dirty_q[s] <= '0;
		end
		else if (req_i.valid)
		begin
			if (is_fill)
				dirty_q[req_set][req_i.fill_way] <= 1'b0;
			else if (hit && is_store)
				dirty_q[req_set][hit_way] <= 1'b1;
			else if (hit && is_flush)
				dirty_q[req_set][hit_way] <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			res_o.valid <= 1'b0;
		else
			res_o.valid <= req_i.valid;
	end

	always_ff @(posedge clk)
	begin
		if (req_i.valid)
		begin
			res_o.hit <= hit;
			res_o.way <= sel_way;
			res_o.dirty <= old_dirty;
			res_o.l1_hit <= l1_hit;
			res_o.l1_way <= l1_way;
			// Eviction details only mean something on a fill
			res_o.old_tag <= is_fill ? req_i.tags[req_i.fill_way] : '0;
			res_o.victim_valid <= is_fill && req_i.valids[req_i.fill_way];
		end
	end

	// Tags written by the tag stage must never make two ways match
	single_l2_hit: assert property (@(posedge clk) disable iff (!reset_n)
		req_i.valid |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

// ==== hw/l2_tag_stage.sv ====
// Tag stage: accepts Wishbone requests, holds L2 tags and valids, picks and writes fill ways
`default_nettype none

module l2_tag_stage (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  l2dir_pkg::line_addr_t wb_adr_i,
	input  l2dir_pkg::l2_op_e     wb_tgc_i,
	input  l2dir_pkg::way_t       wb_tga_i,
	input  logic                  release_i,
	l2_req_if.ready               req_o
);
	import l2dir_pkg::*;

	tag_state_e state_q;
	l2_tag_t [NUM_WAYS-1:0] tags_q [L2_NUM_SETS];
	logic [NUM_WAYS-1:0] valid_q [L2_NUM_SETS];
	way_t rr_q [L2_NUM_SETS];

	logic accept;
	logic fill_req;
	l2_set_t req_set;
	l2_tag_t req_tag;
	logic [NUM_WAYS-1:0] match_vec;
	way_t fill_way;
	logic rr_advance;

	// Only one Wishbone cycle is in flight, so requests wait for release
	assign accept = (state_q == IDLE) && wb_cyc_i && wb_stb_i;
	assign fill_req = accept && (wb_tgc_i == OP_FILL);
	assign req_set = wb_adr_i[L2_SET_WIDTH-1:0];
	assign req_tag = wb_adr_i[LINE_ADDR_WIDTH-1 -: L2_TAG_WIDTH];

	// Victim choice: matching way, else lowest invalid way, else round robin
	always_comb
	begin
		for (int w = 0; w < NUM_WAYS; w++)
			match_vec[w] = valid_q[req_set][w] && (tags_q[req_set][w] == req_tag);
		fill_way = rr_q[req_set];
		rr_advance = 1'b0;
		if (|match_vec)
		begin
			// Line already present, refill it in place
			for (int w = NUM_WAYS - 1; w >= 0; w--)
				if (match_vec[w])
					fill_way = way_t'(w);
		end
		else if (!(&valid_q[req_set]))
		begin
			for (int w = NUM_WAYS - 1; w >= 0; w--)
				if (!valid_q[req_set][w])
					fill_way = way_t'(w);
		end
		else
			rr_advance = 1'b1;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			state_q <= IDLE;
		else if (accept)
			state_q <= BUSY;
		else if (release_i)
			state_q <= IDLE;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			req_o.valid <= 1'b0;
		else
			req_o.valid <= accept;
	end

	// Request and set snapshot, taken before the fill below lands
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_o.op <= wb_tgc_i;
			req_o.addr <= wb_adr_i;
			req_o.l1_way <= wb_tga_i;
			req_o.tags <= tags_q[req_set];
			req_o.valids <= valid_q[req_set];
			req_o.fill_way <= fill_way;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_req)
			tags_q[req_set][fill_way] <= req_tag;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			for (int s = 0; s < L2_NUM_SETS; s++)
			begin
				valid_q[s] <= '0;
				rr_q[s] <= '0;
			end
		end
		else if (fill_req)
		begin
			valid_q[req_set][fill_way] <= 1'b1;
			if (rr_advance)
				rr_q[req_set] <= rr_q[req_set] + 1'b1;
		end
	end

	function automatic logic set_has_dup(l2_set_t set);
		logic dup;
		dup = 1'b0;
		for (int a = 0; a < NUM_WAYS; a++)
			for (int b = a + 1; b < NUM_WAYS; b++)
				if (valid_q[set][a] && valid_q[set][b] && (tags_q[set][a] == tags_q[set][b]))
					dup = 1'b1;
		return dup;
	endfunction

	// The cycle after a fill, the written set holds distinct valid tags
	fill_unique_tags: assert property (@(posedge clk) disable iff (!reset_n)
		req_o.valid && (req_o.op == OP_FILL)
		|-> !set_has_dup(req_o.addr[L2_SET_WIDTH-1:0]));

endmodule

`default_nettype wire

// ==== hw/l1_dir_tags.sv ====
// Copy of the L1 data cache tag memory, looked up and updated by the directory stage
`default_nettype none

module l1_dir_tags (
	input  logic                  clk,
	input  logic                  reset_n,
	input  l2dir_pkg::line_addr_t lookup_addr_i,
	output logic                  hit_o,
	output l2dir_pkg::way_t       hit_way_o,
	input  logic                  update_i,
	input  l2dir_pkg::way_t       update_way_i,
	input  l2dir_pkg::line_addr_t update_addr_i
);
	import l2dir_pkg::*;

	l1_tag_t tag_q [L1_NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS-1:0] valid_q [L1_NUM_SETS];

	l1_set_t lookup_set;
	l1_tag_t lookup_tag;
	l1_set_t update_set;
	l1_tag_t update_tag;
	logic [NUM_WAYS-1:0] hit_vec;
	logic [NUM_WAYS-1:0] dup_vec;
	logic [NUM_WAYS-1:0] way_sel;

	assign lookup_set = lookup_addr_i[L1_SET_WIDTH-1:0];
	assign lookup_tag = lookup_addr_i[LINE_ADDR_WIDTH-1 -: L1_TAG_WIDTH];
	assign update_set = update_addr_i[L1_SET_WIDTH-1:0];
	assign update_tag = update_addr_i[LINE_ADDR_WIDTH-1 -: L1_TAG_WIDTH];
	assign way_sel = NUM_WAYS'(1) << update_way_i;

	// Lookup sees the state before this cycle's update
	always_comb
	begin
		hit_way_o = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			hit_vec[w] = valid_q[lookup_set][w] && (tag_q[lookup_set][w] == lookup_tag);
			if (hit_vec[w])
				hit_way_o = way_t'(w);
			// Same line held in another way gets dropped on update
			dup_vec[w] = valid_q[update_set][w] && (tag_q[update_set][w] == update_tag)
				&& !way_sel[w];
		end
	end

	assign hit_o = |hit_vec;

	always_ff @(posedge clk)
	begin
		if (update_i)
			tag_q[update_set][update_way_i] <= update_tag;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			for (int s = 0; s < L1_NUM_SETS; s++)
				valid_q[s] <= '0;
		end
		else if (update_i)
			valid_q[update_set] <= (valid_q[update_set] & ~dup_vec) | way_sel;
	end

	single_l1_hit: assert property (@(posedge clk) disable iff (!reset_n)
		$onehot0(hit_vec));

endmodule

`default_nettype wire

// ==== hw/l2dir_stage_ifs.sv ====
// Stage-to-stage interfaces of the L2 directory pipeline, instanced by the top level
`default_nettype none

// Tag stage to directory stage, one pulse per accepted request
interface l2_req_if;
	import l2dir_pkg::*;

	logic valid;
	l2_op_e op;
	line_addr_t addr;
	way_t l1_way;
	// Set contents as they were before this request's fill
	l2_tag_t [NUM_WAYS-1:0] tags;
	logic [NUM_WAYS-1:0] valids;
	way_t fill_way;

	modport ready (
		output valid, op, addr, l1_way, tags, valids, fill_way
	);

	modport dir (
		input valid, op, addr, l1_way, tags, valids, fill_way
	);
endinterface

// Directory stage to response stage
interface l2_result_if;
	import l2dir_pkg::*;

	logic valid;
	logic hit;
	way_t way;
	logic dirty;
	logic l1_hit;
	way_t l1_way;
	l2_tag_t old_tag;
	logic victim_valid;

	modport dir (
		output valid, hit, way, dirty, l1_hit, l1_way, old_tag, victim_valid
	);

	modport resp (
		input valid, hit, way, dirty, l1_hit, l1_way, old_tag, victim_valid
	);
endinterface

`default_nettype wire

// ==== hw/l2dir_pkg.sv ====
// Widths, types, operation codes and response bit positions shared by the L2 directory pipeline
`default_nettype none

package l2dir_pkg;

	// Cache-line address split
	localparam int LINE_ADDR_WIDTH = 16;
	localparam int L2_SET_WIDTH = 5;
	localparam int L2_NUM_SETS = 32;
	localparam int L2_TAG_WIDTH = 11;
	localparam int L1_SET_WIDTH = 4;
	localparam int L1_NUM_SETS = 16;
	localparam int L1_TAG_WIDTH = 12;
	localparam int NUM_WAYS = 4;
	localparam int WB_DATA_WIDTH = 32;

	typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;
	typedef logic [L2_TAG_WIDTH-1:0] l2_tag_t;
	typedef logic [L2_SET_WIDTH-1:0] l2_set_t;
	typedef logic [L1_TAG_WIDTH-1:0] l1_tag_t;
	typedef logic [L1_SET_WIDTH-1:0] l1_set_t;
	typedef logic [$clog2(NUM_WAYS)-1:0] way_t;
	typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

	// Operation, carried on the Wishbone cycle tag
	typedef enum logic [1:0] {
		OP_LOAD,
		OP_STORE,
		OP_FLUSH,
		OP_FILL
	} l2_op_e;

	typedef enum logic {
		IDLE,
		BUSY
	} tag_state_e;

	// Response word layout, upper bits read as zero
	localparam int RSP_HIT_BIT = 0;
	localparam int RSP_WAY_LSB = 1;
	localparam int RSP_DIRTY_BIT = 3;
	localparam int RSP_L1_HIT_BIT = 4;
	localparam int RSP_L1_WAY_LSB = 5;
	localparam int RSP_OLD_TAG_LSB = 7;
	localparam int RSP_VICTIM_VALID_BIT = 18;

endpackage

`default_nettype wire
